//--- hdl/csi_rx_consts.svh
// shared constants of the single-lane CSI-2 receiver
// addresses are 2 bits wide, only two of the four are decoded
`ifndef CSI_RX_CONSTS_SVH
`define CSI_RX_CONSTS_SVH

//----------------------------------------------------------------------
// protocol
//----------------------------------------------------------------------
`define CSI_SYNC_BYTE       8'hB8  // start-of-transmission sync pattern
`define CSI_SHORT_DT_MAX    6'h10  // data types below this are short packets

//----------------------------------------------------------------------
// register map
//----------------------------------------------------------------------
`define CSI_REG_CTRL        2'd0   // bit 0 enable, bit 1 invert
`define CSI_REG_PKT_COUNT   2'd1   // low byte of packet count, write clears

`endif

//--- hdl/csi_rx_pkg.sv
// types shared by aligner, parser and top level
// header bytes arrive low byte first: data_id, wc lsb, wc msb, ecc
package csi_rx_pkg;

   // data identifier, virtual channel on top
   typedef struct packed {
      logic [1:0] vc;
      logic [5:0] dt;
   } csi_data_id_t;

   // long packet view, 16-bit field is the payload byte count
   typedef struct packed {
      logic [7:0]   ecc;
      logic [15:0]  word_count;
      csi_data_id_t data_id;
   } csi_long_hdr_t;

   // short packet view, 16-bit field is frame or line number
   typedef struct packed {
      logic [7:0]   ecc;
      logic [15:0]  frame_line_number;
      csi_data_id_t data_id;
   } csi_short_hdr_t;

   typedef union packed {
      csi_long_hdr_t  long_view;
      csi_short_hdr_t short_view;
   } csi_header_t;

   typedef enum logic {ALIGN_HUNT, ALIGN_LOCKED} align_state_t;

   typedef enum logic [1:0] {
      PARSE_IDLE, PARSE_HEADER, PARSE_PAYLOAD, PARSE_CHECKSUM
   } parse_state_t;

endpackage

//--- hdl/csi_lane_if.sv
// aligned byte stream from sync aligner to packet parser
// no back-pressure, the sink must take every data_valid pulse
`timescale 1ns/1ps

interface csi_lane_if;

   logic [7:0] data;        // aligned byte
   logic       data_valid;  // one pulse per byte
   logic       sot;         // single pulse when the aligner locks
   logic       locked;      // level, high for the rest of the burst

   modport source (
      output data, data_valid, sot, locked
   );

   modport sink (
      input data, data_valid, sot, locked
   );

endinterface

//--- hdl/csi_rx_regs.sv
// control register and packet counter
// count saturates at ffff, only its low byte is readable
`timescale 1ns/1ps
`include "csi_rx_consts.svh"

module csi_rx_regs (
   input  logic       bit_clock,
   input  logic       rst_n,
   input  logic       reg_write,
   input  logic [1:0] reg_addr,
   input  logic [7:0] reg_wdata,
   input  logic       packet_done,  // one pulse per finished packet
   output logic [7:0] reg_rdata,
   output logic       rx_enable,
   output logic       invert
);

   logic [1:0]  ctrl_q;   // [1] invert, [0] enable
   logic [15:0] count_q;

   //----------------------------------------------------------------------
   // write side
   //----------------------------------------------------------------------
   always_ff @(posedge bit_clock or negedge rst_n) begin
      if (!rst_n) begin
         ctrl_q  <= 2'b00;      // receiver off after reset
         count_q <= 16'd0;
      end else begin
         if (reg_write && reg_addr == `CSI_REG_CTRL)
            ctrl_q <= reg_wdata[1:0];
         // clear wins over a packet ending in the same cycle
         if (reg_write && reg_addr == `CSI_REG_PKT_COUNT)
            count_q <= 16'd0;
         else if (packet_done && count_q != 16'hFFFF)
            count_q <= count_q + 16'd1;
      end
   end

   assign rx_enable = ctrl_q[0];
   assign invert    = ctrl_q[1];

   // read mux, unmapped addresses return zero
   always_comb begin
      unique case (reg_addr)
         `CSI_REG_CTRL:      reg_rdata = {6'd0, ctrl_q};
         `CSI_REG_PKT_COUNT: reg_rdata = count_q[7:0];
         default:            reg_rdata = 8'h00;
      endcase
   end

endmodule

//--- hdl/csi_lane_deser.sv
// single-rate serial to byte shifter, one bit per bit_clock, lsb first
// byte boundaries are arbitrary, the sync aligner fixes them later
`timescale 1ns/1ps

module csi_lane_deser (
   input  logic       bit_clock,
   input  logic       rst_n,
   input  logic       rx_enable,
   input  logic       invert,      // set when the lane pair is swapped
   input  logic       serial_in,
   output logic [7:0] byte_data,   // 8 newest bits, newest in msb
   output logic       byte_valid   // pulse every 8th enabled cycle
);

   logic [2:0] phase_q;  // bit position inside current byte
   logic [7:0] shift_q;

   always_ff @(posedge bit_clock or negedge rst_n) begin
      if (!rst_n) begin
         phase_q    <= 3'd0;
         shift_q    <= 8'h00;
         byte_valid <= 1'b0;
      end else if (rx_enable) begin
         phase_q    <= phase_q + 3'd1;               // wraps every 8 bits
         shift_q    <= {serial_in, shift_q[7:1]};    // newest bit enters at msb
         byte_valid <= (phase_q == 3'd7);            // strobe on wrap
      end else begin
         // disabled: counter parked, no strobe
         phase_q    <= 3'd0;
         byte_valid <= 1'b0;
      end
   end

   // polarity fix on the parallel side, same effect as on the wire
   assign byte_data = invert ? ~shift_q : shift_q;

endmodule

//--- hdl/csi_sync_aligner.sv
// hunts the sync byte over 8 bit offsets of a 16-bit window
// lock holds until lane_active drops, sync byte itself is not forwarded
`timescale 1ns/1ps
`include "csi_rx_consts.svh"

module csi_sync_aligner (
   input  logic       bit_clock,
   input  logic       rst_n,
   input  logic       lane_active,  // high for the whole hs burst
   input  logic [7:0] byte_data,
   input  logic       byte_valid,
   csi_lane_if.source lane
);

   csi_rx_pkg::align_state_t state_q;

   logic [7:0]  prev_q;       // byte before the current one
   logic [15:0] window;       // older byte in the low half
   logic [2:0]  offset_q;     // locked bit offset
   logic [2:0]  hit_offset;
   logic        hit;
   logic [7:0]  data_q;
   logic        data_valid_q;
   logic        sot_q;

   assign window = {byte_data, prev_q};

   //----------------------------------------------------------------------
   // sync search, lowest offset is the earliest in time and wins
   //----------------------------------------------------------------------
   always_comb begin
      hit        = 1'b0;
      hit_offset = 3'd0;
      for (int i = 7; i >= 0; i--) begin
         if (window[i +: 8] == `CSI_SYNC_BYTE) begin
            hit        = 1'b1;
            hit_offset = 3'(i);
         end
      end
   end

   //----------------------------------------------------------------------
   // hunt / lock control
   //----------------------------------------------------------------------
   always_ff @(posedge bit_clock or negedge rst_n) begin
      if (!rst_n) begin
         state_q      <= csi_rx_pkg::ALIGN_HUNT;
         prev_q       <= 8'h00;
         offset_q     <= 3'd0;
         data_valid_q <= 1'b0;
         sot_q        <= 1'b0;
      end else begin
         sot_q        <= 1'b0;                     // pulses by default
         data_valid_q <= 1'b0;
         if (!lane_active) begin
            state_q <= csi_rx_pkg::ALIGN_HUNT;   // burst over, forget the offset
            prev_q  <= 8'h00;                    // no stale bits in the next hunt
         end else if (byte_valid) begin
            prev_q <= byte_data;
            if (state_q == csi_rx_pkg::ALIGN_HUNT) begin
               if (hit) begin
                  state_q  <= csi_rx_pkg::ALIGN_LOCKED;
                  offset_q <= hit_offset;
                  sot_q    <= 1'b1;
               end
            end else begin
               data_valid_q <= 1'b1;
            end
         end
      end
   end

   // aligned byte extract
   always_ff @(posedge bit_clock) begin
      if (byte_valid && state_q == csi_rx_pkg::ALIGN_LOCKED)
         data_q <= window[offset_q +: 8];
   end

   assign lane.data       = data_q;
   assign lane.data_valid = data_valid_q;
   assign lane.sot        = sot_q;
   assign lane.locked     = (state_q == csi_rx_pkg::ALIGN_LOCKED);

endmodule

//--- hdl/csi_packet_parser.sv
// csi-2 packet header decode and payload forwarding
// ecc is captured but not checked, checksum bytes are dropped unchecked
`timescale 1ns/1ps
`include "csi_rx_consts.svh"

module csi_packet_parser (
   input  logic                    bit_clock,
   input  logic                    rst_n,
   csi_lane_if.sink                lane,
   output logic                    header_valid,   // one cycle after 4th header byte
   output csi_rx_pkg::csi_header_t header,
   output logic                    short_packet,   // level, valid with header_valid
   output logic [7:0]              payload_data,
   output logic                    payload_valid,
   output logic                    packet_done     // end of every complete packet
);

   csi_rx_pkg::parse_state_t state_q;
   csi_rx_pkg::csi_header_t  hdr_q;
   csi_rx_pkg::csi_header_t  next_hdr;

   logic [1:0]  cnt_q;        // header or checksum byte index
   logic [15:0] remaining_q;  // payload bytes still due
   logic        is_short;
   logic        take;

   // header shifts in from the top, first byte ends in [7:0]
   assign next_hdr = {lane.data, hdr_q[31:8]};
   assign is_short = next_hdr.short_view.data_id.dt < `CSI_SHORT_DT_MAX;
   assign take     = lane.data_valid && lane.locked;

   //----------------------------------------------------------------------
   // packet FSM
   //----------------------------------------------------------------------
   always_ff @(posedge bit_clock or negedge rst_n) begin
      if (!rst_n) begin
         state_q       <= csi_rx_pkg::PARSE_IDLE;
         cnt_q         <= 2'd0;
         remaining_q   <= 16'd0;
         short_packet  <= 1'b0;
         header_valid  <= 1'b0;
         payload_valid <= 1'b0;
         packet_done   <= 1'b0;
      end else begin
         header_valid  <= 1'b0;
         payload_valid <= 1'b0;
         packet_done   <= 1'b0;
         if (!lane.locked) begin
            state_q <= csi_rx_pkg::PARSE_IDLE;   // lock lost, abort silently
         end else begin
            unique case (state_q)
               csi_rx_pkg::PARSE_IDLE: begin
                  cnt_q <= 2'd0;
                  if (lane.sot) state_q <= csi_rx_pkg::PARSE_HEADER;
               end
               csi_rx_pkg::PARSE_HEADER: if (take) begin
                  cnt_q <= cnt_q + 2'd1;
                  if (cnt_q == 2'd3) begin              // ecc byte closes the header
                     header_valid <= 1'b1;
                     short_packet <= is_short;
                     remaining_q  <= next_hdr.long_view.word_count;
                     cnt_q        <= 2'd0;
                     if (is_short) begin
                        packet_done <= 1'b1;
                        state_q     <= csi_rx_pkg::PARSE_IDLE;
                     end else if (next_hdr.long_view.word_count == 16'd0) begin
                        state_q <= csi_rx_pkg::PARSE_CHECKSUM;
                     end else begin
                        state_q <= csi_rx_pkg::PARSE_PAYLOAD;
                     end
                  end
               end
               csi_rx_pkg::PARSE_PAYLOAD: if (take) begin
                  payload_valid <= 1'b1;
                  remaining_q   <= remaining_q - 16'd1;
                  if (remaining_q == 16'd1) state_q <= csi_rx_pkg::PARSE_CHECKSUM;
               end
               csi_rx_pkg::PARSE_CHECKSUM: if (take) begin
                  cnt_q <= cnt_q + 2'd1;
                  if (cnt_q == 2'd1) begin              // second crc byte
                     packet_done <= 1'b1;
                     state_q     <= csi_rx_pkg::PARSE_IDLE;
                  end
               end
               default: state_q <= csi_rx_pkg::PARSE_IDLE;
            endcase
         end
      end
   end

   // payload side, no reset needed
   always_ff @(posedge bit_clock) begin
      if (take && state_q == csi_rx_pkg::PARSE_HEADER) hdr_q <= next_hdr;
      if (take && state_q == csi_rx_pkg::PARSE_PAYLOAD) payload_data <= lane.data;
   end

   assign header = hdr_q;

endmodule

//--- hdl/csi_rx_top.sv
// single-lane csi-2 receiver, one clock domain at bit rate
// receiver stays off until enable is written to the control register
`timescale 1ns/1ps

module csi_rx_top (
   input  logic        bit_clock,
   input  logic        rst_n,
   input  logic        serial_in,
   input  logic        lane_active,
   input  logic        reg_write,
   input  logic [1:0]  reg_addr,
   input  logic [7:0]  reg_wdata,
   output logic [7:0]  reg_rdata,
   output logic        header_valid,
   output logic [7:0]  data_id,
   output logic [15:0] header_field,   // word count or frame/line number
   output logic        short_packet,
   output logic [7:0]  payload_data,
   output logic        payload_valid
);

   logic                    rx_enable;
   logic                    invert;
   logic                    packet_done;
   logic [7:0]              byte_data;
   logic                    byte_valid;
   csi_rx_pkg::csi_header_t header;

   csi_lane_if lane_bus ();

   csi_rx_regs i_regs (
      .bit_clock, .rst_n, .reg_write, .reg_addr, .reg_wdata,
      .packet_done, .reg_rdata, .rx_enable, .invert
   );

   csi_lane_deser i_deser (
      .bit_clock, .rst_n, .rx_enable, .invert, .serial_in,
      .byte_data, .byte_valid
   );

   csi_sync_aligner i_aligner (
      .bit_clock, .rst_n, .lane_active, .byte_data, .byte_valid,
      .lane (lane_bus.source)
   );

   csi_packet_parser i_parser (
      .bit_clock, .rst_n, .lane (lane_bus.sink),
      .header_valid, .header, .short_packet,
      .payload_data, .payload_valid, .packet_done
   );

   // same bits in both header views
   assign data_id      = header.long_view.data_id;
   assign header_field = header.long_view.word_count;

endmodule

//--- tb/csi_rx_properties.sv
// strobe and lock checks, one checker bound into aligner and parser
// inputs that a block does not have are tied to constants in its bind
`timescale 1ns/1ps

module csi_rx_properties (
   input logic bit_clock,
   input logic rst_n,
   input logic lane_active,
   input logic hunting,        // aligner still searching for sync
   input logic sot,
   input logic data_valid,
   input logic locked,
   input logic header_valid,
   input logic payload_valid
);

   // one aligned byte per 8 bit times at most
   a_data_valid_gap: assert property (@(posedge bit_clock) disable iff (!rst_n)
      data_valid |=> !data_valid) else $error("data_valid high in two consecutive cycles");

   // sot closes a hunt and reaches the parser while the burst is still live
   a_sot_in_hunt: assert property (@(posedge bit_clock) disable iff (!rst_n)
      sot |-> $past(hunting) && lane_active) else $error("sot outside hunt or burst");

   // lock still held when the registered payload strobe comes out
   a_payload_locked: assert property (@(posedge bit_clock) disable iff (!rst_n)
      payload_valid |-> locked) else $error("payload_valid without lock");

   a_header_gap: assert property (@(posedge bit_clock) disable iff (!rst_n)
      header_valid |=> !header_valid) else $error("header_valid high in two consecutive cycles");

endmodule

bind csi_sync_aligner csi_rx_properties i_align_props (
   .bit_clock, .rst_n, .lane_active,
   .hunting       (state_q == csi_rx_pkg::ALIGN_HUNT),
   .sot           (sot_q),
   .data_valid    (data_valid_q),
   .locked        (1'b1),
   .header_valid  (1'b0),
   .payload_valid (1'b0)
);

bind csi_packet_parser csi_rx_properties i_parse_props (
   .bit_clock, .rst_n,
   .lane_active   (1'b1),
   .hunting       (1'b1),
   .sot           (1'b0),
   .data_valid    (1'b0),
   .locked        (lane.locked),
   .header_valid, .payload_valid
);

//--- tb/csi_rx_tb.sv
// random-burst testbench for the single-lane csi-2 receiver
// bursts in the second half run inverted on the wire and in the DUT
// a burst stays open until the packet counter moves, then the line idles
`timescale 1ns/1ps
`include "csi_rx_consts.svh"

module csi_rx_tb;

   localparam int NUM_BURSTS     = 20;
   localparam int MAX_BURST_BITS = 15 + 8 + 8 * (4 + 12 + 2);  // lead-in, sync, longest packet
   localparam int CYCLE_LIMIT    = 3 * NUM_BURSTS * MAX_BURST_BITS + 200;

   logic        bit_clock;
   logic        rst_n;
   logic        serial_in;
   logic        lane_active;
   logic        reg_write;
   logic [1:0]  reg_addr;
   logic [7:0]  reg_wdata;
   logic [7:0]  reg_rdata;
   logic        header_valid;
   logic [7:0]  data_id;
   logic [15:0] header_field;
   logic        short_packet;
   logic [7:0]  payload_data;
   logic        payload_valid;

   integer      seed = 32'h47b1a4df;
   logic        line_inv;             // wire polarity on the tb side
   int          cycles = 0;
   int          headers_seen = 0;
   logic [24:0] exp_hdr_q[$];         // {short, data_id, field}
   logic [7:0]  exp_payload_q[$];

   csi_rx_top i_dut (.*);

   initial begin
      bit_clock = 1'b0;
      forever #5 bit_clock = ~bit_clock;
   end

   //----------------------------------------------------------------------
   // error handling and compare
   //----------------------------------------------------------------------
   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("Checks failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
         stop_on_error($sformatf("mismatch %s: got 0x%0h, expected 0x%0h",
                                 name, actual, expected));
   endtask

   always @(posedge bit_clock) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT)
         stop_on_error($sformatf("timeout, run still going after %0d cycles", cycles));
   end

   //----------------------------------------------------------------------
   // line and register drivers, all on the falling edge
   //----------------------------------------------------------------------
   task automatic send_bit(input logic b);
      @(negedge bit_clock);
      lane_active = 1'b1;
      serial_in   = b ^ line_inv;
   endtask

   task automatic send_byte(input logic [7:0] b);
      for (int i = 0; i < 8; i++)
         send_bit(b[i]);                  // lsb first on the wire
   endtask

   task automatic idle_line(input int n);
      repeat (n) begin
         @(negedge bit_clock);
         lane_active = 1'b0;
         serial_in   = line_inv;          // logical zero
      end
   endtask

   task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
      @(negedge bit_clock);
      reg_write = 1'b1;
      reg_addr  = addr;
      reg_wdata = data;
      @(negedge bit_clock);
      reg_write = 1'b0;
      reg_addr  = `CSI_REG_PKT_COUNT;     // parked on the counter between accesses
   endtask

   task automatic expect_reg(input logic [1:0] addr, input logic [7:0] value);
      @(negedge bit_clock);
      reg_addr = addr;
      #1;                                 // read path is combinational
      check_value("reg_rdata", 32'(reg_rdata), 32'(value));
      reg_addr = `CSI_REG_PKT_COUNT;
   endtask

   //----------------------------------------------------------------------
   // one burst: lead-in, sync, random packet, wait for the count
   //----------------------------------------------------------------------
   task automatic send_burst(input int n);
      logic [7:0]  bytes[$];
      logic [5:0]  dt;
      logic [1:0]  vc;
      logic [7:0]  ecc;
      logic [15:0] field;
      logic        is_short;
      int          lead;
      dt       = 6'($random(seed));
      vc       = 2'($random(seed));
      ecc      = 8'($random(seed));
      lead     = $random(seed) & 15;
      is_short = dt < `CSI_SHORT_DT_MAX;
      if (is_short)
         field = 16'($random(seed));                    // frame or line number
      else
         field = 16'($unsigned($random(seed)) % 13);    // word count 0..12
      exp_hdr_q.push_back({is_short, vc, dt, field});
      bytes = '{{vc, dt}, field[7:0], field[15:8], ecc};  // header, low byte first
      if (!is_short) begin
         for (int i = 0; i < int'(field); i++) begin
            bytes.push_back(8'($random(seed)));
            exp_payload_q.push_back(bytes[$]);
         end
         bytes.push_back(8'($random(seed)));            // checksum, never forwarded
         bytes.push_back(8'($random(seed)));
      end
      repeat (lead) send_bit(1'b0);
      send_byte(`CSI_SYNC_BYTE);
      foreach (bytes[i]) send_byte(bytes[i]);
      while (reg_rdata != 8'(n + 1))
         send_bit(1'b0);                  // flush until packet_done is counted
      idle_line(6);
      check_value("headers_seen", headers_seen, n + 1);
      check_value("payload bytes left", exp_payload_q.size(), 0);
   endtask

   // output monitor, sampled away from the rising edge
   always @(negedge bit_clock) begin
      logic [24:0] exp_hdr;
      if (rst_n && header_valid) begin
         if (exp_hdr_q.size() == 0) begin
            stop_on_error("header_valid pulsed with no packet outstanding");
         end else begin
            exp_hdr = exp_hdr_q.pop_front();
            check_value("data_id", 32'(data_id), 32'(exp_hdr[23:16]));
            check_value("header_field", 32'(header_field), 32'(exp_hdr[15:0]));
            check_value("short_packet", 32'(short_packet), 32'(exp_hdr[24]));
            headers_seen++;
         end
      end
      if (rst_n && payload_valid) begin
         if (exp_payload_q.size() == 0)
            stop_on_error("payload_valid pulsed with no payload byte outstanding");
         else
            check_value("payload_data", 32'(payload_data), 32'(exp_payload_q.pop_front()));
      end
   end

   initial begin
      rst_n       = 1'b0;
      serial_in   = 1'b0;
      lane_active = 1'b0;
      reg_write   = 1'b0;
      reg_addr    = `CSI_REG_PKT_COUNT;
      reg_wdata   = 8'h00;
      line_inv    = 1'b0;
      repeat (4) @(negedge bit_clock);
      rst_n = 1'b1;
      expect_reg(`CSI_REG_CTRL, 8'h00);           // off after reset
      write_reg(`CSI_REG_CTRL, 8'h01);
      expect_reg(`CSI_REG_CTRL, 8'h01);
      idle_line(10);
      for (int n = 0; n < NUM_BURSTS; n++) begin
         if (n == NUM_BURSTS / 2) begin
            write_reg(`CSI_REG_CTRL, 8'h03);      // enable plus invert
            expect_reg(`CSI_REG_CTRL, 8'h03);
            line_inv = 1'b1;
            idle_line(10);                        // let the shifter refill
         end
         send_burst(n);
      end
      expect_reg(`CSI_REG_PKT_COUNT, 8'(NUM_BURSTS));
      write_reg(`CSI_REG_PKT_COUNT, 8'h00);       // clear
      expect_reg(`CSI_REG_PKT_COUNT, 8'h00);
      $display("All checks passed");
      $finish;
   end

endmodule

//--- list.f
+incdir+hdl
hdl/csi_rx_pkg.sv
hdl/csi_lane_if.sv
hdl/csi_rx_regs.sv
hdl/csi_lane_deser.sv
hdl/csi_sync_aligner.sv
hdl/csi_packet_parser.sv
hdl/csi_rx_top.sv
tb/csi_rx_properties.sv
tb/csi_rx_tb.sv

//--- Makefile
# Verilator build and run of the csi-2 receiver testbench
# exit status of the simulation is the pass or fail result

VERILATOR ?= verilator
TOP       ?= csi_rx_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)
